//--- Bender.yml
package:
  name: line_stream

sources:
  - files:
      - hw/stream_pkg.sv
      - hw/line_pkg.sv
      - hw/line_unpacker.sv
      - hw/word_transform.sv
      - hw/line_packer.sv
      - hw/line_stream_top.sv
  - target: test
    files:
      - sim/line_stream_tb.sv

//--- all.f
hw/stream_pkg.sv
hw/line_pkg.sv
hw/line_unpacker.sv
hw/word_transform.sv
hw/line_packer.sv
hw/line_stream_top.sv
sim/line_stream_tb.sv

//--- hw/line_packer.sv
`timescale 1ns/1ps

module line_packer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          wr_available,
  output logic                          wr_en,
  output logic [line_pkg::LINE_W-1:0]   wr_data,
  input  logic                          req,
  output logic                          ack,
  input  stream_pkg::tagged_word_t      word,
  output logic                          done
);
  import stream_pkg::*;
  import line_pkg::*;

  localparam int SLOT_W = $clog2(WORDS_PER_LINE);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_done
  } state_e;

  state_e                                state;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] acc;        // Line being gathered
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] acc_next;
  logic [SLOT_W-1:0]                     slot;
  logic                                  partial;    // At least one word in acc
  logic                                  go;

  assign go = start && wr_available;                 // Qualifying cycle

  always_comb begin
    acc_next       = acc;
    acc_next[slot] = word.payload;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_idle;
      wr_en   <= 1'b0;
      ack     <= 1'b0;
      acc     <= '0;
      slot    <= '0;
      partial <= 1'b0;
      done    <= 1'b0;
    end else begin
      wr_en <= 1'b0;                                 // Single-cycle pulse even when stalled
      if (go) begin
        case (state)
          st_idle: begin
            if (req) begin
              ack   <= 1'b1;
              state <= st_wait;
              case (word.tag)
                tag_data: begin
                  if (slot == SLOT_W'(WORDS_PER_LINE - 1)) begin
                    wr_data <= acc_next;             // Full line out with the ack
                    wr_en   <= 1'b1;
                    acc     <= '0;
                    slot    <= '0;
                    partial <= 1'b0;
                  end else begin
                    acc     <= acc_next;
                    slot    <= slot + SLOT_W'(1);
                    partial <= 1'b1;
                  end
                end
                tag_end: begin
                  if (partial) begin
                    wr_data <= acc;                  // Upper words still zero
                    wr_en   <= 1'b1;
                  end
                  state <= st_done;
                end
                default: ;
              endcase
            end
          end
          st_wait: begin
            if (!req) begin
              ack   <= 1'b0;
              state <= st_idle;
            end
          end
          st_done: begin
            if (!req) begin
              ack <= 1'b0;
            end
            done <= 1'b1;                            // Sticky until rst
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

endmodule

//--- hw/line_pkg.sv
package line_pkg;

  localparam int LINE_W         = 512;
  localparam int WORDS_PER_LINE = LINE_W / stream_pkg::WORD_W;   // 16 words per line

  // Per-run settings held stable while start is high
  typedef struct packed {
    logic [15:0] num_words;                          // Data words in the run
    logic [31:0] gain;
    logic [31:0] offset;
  } run_cfg_t;

endpackage

//--- hw/line_stream_top.sv
`timescale 1ns/1ps

module line_stream_top #(
  parameter int COUNT_W = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  line_pkg::run_cfg_t            cfg,
  input  logic                          rd_available,
  output logic                          rd_en,
  input  logic [line_pkg::LINE_W-1:0]   rd_data,
  input  logic                          wr_available,
  output logic                          wr_en,
  output logic [line_pkg::LINE_W-1:0]   wr_data,
  output logic                          done
);
  import stream_pkg::*;

  logic         req_a;                               // Link A from unpacker to transform
  logic         ack_a;
  tagged_word_t word_a;
  logic         req_b;                               // Link B from transform to packer
  logic         ack_b;
  tagged_word_t word_b;

  line_unpacker #(
    .COUNT_W (COUNT_W)
  ) line_unpacker_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .cfg          (cfg),
    .rd_available (rd_available),
    .rd_en        (rd_en),
    .rd_data      (rd_data),
    .req          (req_a),
    .ack          (ack_a),
    .word         (word_a)
  );

  word_transform word_transform_i (
    .clk      (clk),
    .rst      (rst),
    .cfg      (cfg),
    .in_req   (req_a),
    .in_ack   (ack_a),
    .in_word  (word_a),
    .out_req  (req_b),
    .out_ack  (ack_b),
    .out_word (word_b)
  );

  line_packer line_packer_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .wr_available (wr_available),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .req          (req_b),
    .ack          (ack_b),
    .word         (word_b),
    .done         (done)
  );

endmodule

//--- hw/line_unpacker.sv
`timescale 1ns/1ps

module line_unpacker #(
  parameter int COUNT_W = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  line_pkg::run_cfg_t            cfg,
  input  logic                          rd_available,
  output logic                          rd_en,
  input  logic [line_pkg::LINE_W-1:0]   rd_data,
  output logic                          req,
  input  logic                          ack,
  output stream_pkg::tagged_word_t      word
);
  import stream_pkg::*;
  import line_pkg::*;

  localparam int IDX_W = $clog2(WORDS_PER_LINE);

  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_send,
    st_wait_ack_low,
    st_finish
  } state_e;

  state_e                               state;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_q;     // Current input line
  logic [IDX_W-1:0]                     idx;
  logic [COUNT_W-1:0]                   remaining;   // Data words still to send
  logic                                 rd_pend;     // Read issued and data due next cycle
  logic                                 end_phase;   // Sending the end tag

  // Read only when the line register is empty and words remain
  assign rd_en = (state == st_fetch) && start && rd_available && !rd_pend &&
                 (remaining != '0);

  // Word is held steady by line_q and idx while req is high
  always_comb begin
    if (end_phase) begin
      word.tag     = tag_end;
      word.payload = '0;
    end else begin
      word.tag     = tag_data;
      word.payload = line_q[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      req       <= 1'b0;
      rd_pend   <= 1'b0;
      end_phase <= 1'b0;
      idx       <= '0;
      remaining <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            remaining <= COUNT_W'(cfg.num_words);
            state     <= st_fetch;
          end
        end
        st_fetch: begin
          if (remaining == '0) begin
            end_phase <= 1'b1;
            req       <= 1'b1;
            state     <= st_send;
          end else if (rd_pend) begin
            rd_pend <= 1'b0;
            line_q  <= rd_data;                      // Captured one cycle after rd_en
            idx     <= '0;
            req     <= 1'b1;
            state   <= st_send;
          end else if (rd_en) begin
            rd_pend <= 1'b1;
          end
        end
        st_send: begin
          if (ack) begin
            req <= 1'b0;
            if (!end_phase) begin
              remaining <= remaining - COUNT_W'(1);
            end
            state <= st_wait_ack_low;
          end
        end
        st_wait_ack_low: begin
          if (!ack) begin
            if (end_phase) begin
              state <= st_finish;
            end else if (remaining == '0) begin
              end_phase <= 1'b1;
              req       <= 1'b1;
              state     <= st_send;
            end else if (idx == IDX_W'(WORDS_PER_LINE - 1)) begin
              state <= st_fetch;                     // Line used up
            end else begin
              idx   <= idx + IDX_W'(1);
              req   <= 1'b1;
              state <= st_send;
            end
          end
        end
        st_finish: state <= st_finish;               // Only rst leaves
        default:   state <= st_idle;
      endcase
    end
  end

endmodule

//--- hw/stream_pkg.sv
package stream_pkg;

  localparam int WORD_W = 32;                        // Payload width of one link word

  // Word tag carried in the upper two bits of every link word
  typedef enum logic [1:0] {
    tag_none = 2'd0,                                 // Ignored by the packer
    tag_data = 2'd1,
    tag_end  = 2'd2                                  // Closes the stream
  } word_tag_e;

  typedef struct packed {
    word_tag_e           tag;                        // Bits 33:32
    logic [WORD_W-1:0]   payload;                    // Bits 31:0
  } tagged_word_t;

endpackage

//--- hw/word_transform.sv
`timescale 1ns/1ps

module word_transform (
  input  logic                      clk,
  input  logic                      rst,
  input  line_pkg::run_cfg_t        cfg,
  input  logic                      in_req,
  output logic                      in_ack,
  input  stream_pkg::tagged_word_t  in_word,
  output logic                      out_req,
  input  logic                      out_ack,
  output stream_pkg::tagged_word_t  out_word
);
  import stream_pkg::*;

  tagged_word_t hold;                                // One-word holding slot
  logic         full;
  tagged_word_t result;

  // Gain and offset apply to data only and keep the low 32 bits
  always_comb begin
    result = hold;
    if (hold.tag == tag_data) begin
      result.payload = hold.payload * cfg.gain + cfg.offset;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ack  <= 1'b0;
      out_req <= 1'b0;
      full    <= 1'b0;
    end else begin
      // Input side latches and acks once the previous cycle has closed
      if (!in_ack && in_req && !full) begin
        hold   <= in_word;
        full   <= 1'b1;
        in_ack <= 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end

      // Output side presents the result when link B is idle
      if (full && !out_req && !out_ack) begin
        out_word <= result;
        out_req  <= 1'b1;
        full     <= 1'b0;
      end else if (out_req && out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

endmodule

//--- sim/line_stream_tb.sv
`timescale 1ns/1ps

module line_stream_tb;
  import stream_pkg::*;
  import line_pkg::*;

  localparam int NUM_ROWS     = 6;
  localparam int MAX_LINES    = 4;
  localparam int RST_CYCLES   = 8;
  localparam int DONE_TIMEOUT = 5000;
  localparam int HOLD_CYCLES  = 20;                  // Watch done and wr_en after the run

  typedef struct packed {
    logic [15:0] num_words;
    logic [31:0] gain;
    logic [31:0] offset;
    logic [31:0] rd_mask;                            // One bit per 4-cycle step
    logic [31:0] wr_mask;                            // One bit per cycle
    logic        wr_rand;                            // Fresh xorshift mask every 32 cycles
    logic [7:0]  exp_lines;
  } row_t;

  logic               clk = 1'b0;
  logic               rst = 1'b1;
  logic               start = 1'b0;
  run_cfg_t           cfg = '0;
  logic               rd_available = 1'b0;
  logic               rd_en;
  logic [LINE_W-1:0]  rd_data = '0;
  logic               wr_available = 1'b0;
  logic               wr_en;
  logic [LINE_W-1:0]  wr_data;
  logic               done;

  row_t               rows [NUM_ROWS];
  logic [LINE_W-1:0]  mem [MAX_LINES];               // Upstream line buffer
  logic [LINE_W-1:0]  exp_lines [MAX_LINES];         // Reference model output
  logic [31:0]        rng_state = 32'hbd90;
  logic [31:0]        rd_mask_row = '0;
  logic [31:0]        wr_mask_row = '0;
  logic [31:0]        wr_bits = '0;
  logic               wr_rand = 1'b0;
  logic [31:0]        cyc = '0;
  int                 cur_lines = 0;
  int                 out_count = 0;
  int                 rd_count = 0;
  logic               done_seen = 1'b0;
  logic               rst_d = 1'b0;
  int                 errors = 0;
  int                 timeouts = 0;

  line_stream_top #(
    .COUNT_W (16)
  ) line_stream_top_i (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .cfg          (cfg),
    .rd_available (rd_available),
    .rd_en        (rd_en),
    .rd_data      (rd_data),
    .wr_available (wr_available),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .done         (done)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic row_t make_row(input logic [15:0] n, input logic [31:0] g,
                                    input logic [31:0] o, input logic [31:0] rm,
                                    input logic [31:0] wm, input logic rnd,
                                    input logic [7:0] el);
    row_t t;
    t.num_words = n;
    t.gain      = g;
    t.offset    = o;
    t.rd_mask   = rm;
    t.wr_mask   = wm;
    t.wr_rand   = rnd;
    t.exp_lines = el;
    return t;
  endfunction

  task automatic check_eq(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                          input string msg);
    if (got !== exp) begin
      errors++;
      $display("ERR @ %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  // Buffer levels follow the row masks
  always @(posedge clk) begin
    if (!wr_rand) begin
      wr_bits = wr_mask_row;
    end else if (cyc[4:0] == 5'd0) begin
      wr_bits = next_rand();
    end
    wr_available <= wr_bits[cyc[4:0]];
    rd_available <= rd_mask_row[cyc[6:2]];           // Slow steps give long low stretches
    cyc = cyc + 32'd1;
  end

  // Memory model returns the next line one cycle after rd_en
  always @(posedge clk) begin
    if (rst) begin
      rd_count = 0;
    end else if (rd_en) begin
      if (rd_count < MAX_LINES) begin
        rd_data <= mem[rd_count];
      end else begin
        check_eq(rd_count, MAX_LINES - 1, "read beyond end of line memory");
      end
      rd_count++;
    end
  end

  // Output and done checker
  always @(posedge clk) begin
    if (rst) begin
      out_count = 0;
      done_seen = 1'b0;
      if (rst_d) begin
        check_eq(done, 1'b0, "done during reset");
      end
    end else begin
      if (wr_en) begin
        if (out_count < cur_lines) begin
          check_eq(wr_data, exp_lines[out_count], $sformatf("output line %0d", out_count));
        end else begin
          check_eq(wr_en, 1'b0, "extra wr_en pulse");
        end
        out_count++;
      end
      if (done_seen) begin
        check_eq(done, 1'b1, "done dropped before reset");
      end else if (done) begin
        check_eq(out_count, cur_lines, "lines written when done rose");
        done_seen = 1'b1;
      end
      check_eq(rd_en & ~rd_available, 1'b0, "rd_en while rd_available low");
    end
    rst_d = rst;
  end

  task automatic run_row(input row_t row, input int idx);
    int          i;
    int          l;
    int          w;
    logic [31:0] word;
    @(posedge clk);
    rst   <= 1'b1;
    start <= 1'b0;
    cfg   <= {row.num_words, row.gain, row.offset};
    @(negedge clk);
    rd_mask_row = row.rd_mask;
    wr_mask_row = row.wr_mask;
    wr_rand     = row.wr_rand;
    cur_lines   = row.exp_lines;
    for (l = 0; l < MAX_LINES; l++) begin
      for (w = 0; w < WORDS_PER_LINE; w++) begin
        word = next_rand();
        mem[l][w*WORD_W +: WORD_W] = word;
        if (l * WORDS_PER_LINE + w < row.num_words) begin
          exp_lines[l][w*WORD_W +: WORD_W] = word * row.gain + row.offset;
        end else begin
          exp_lines[l][w*WORD_W +: WORD_W] = '0;     // Unfilled words of a partial line
        end
      end
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    start <= 1'b1;
    i = 0;
    while (!done && i < DONE_TIMEOUT) begin
      @(posedge clk);
      i++;
    end
    if (!done) begin
      timeouts++;
      $display("Timeout in row %0d: done did not rise within %0d cycles", idx, DONE_TIMEOUT);
    end else begin
      repeat (HOLD_CYCLES) @(posedge clk);
      check_eq(out_count, row.exp_lines, $sformatf("row %0d lines written", idx));
      check_eq(rd_count, row.exp_lines, $sformatf("row %0d lines read", idx));
    end
  endtask

  initial begin
    int r;
    rows[0] = make_row(16'd32, 32'd1, 32'd0, '1, '1, 1'b0, 8'd2);
    rows[1] = make_row(16'd20, 32'h0001_0003, 32'h1234_5678, '1, '1, 1'b0, 8'd2);
    rows[2] = make_row(16'd45, 32'd7, 32'hdead_0001, '1, '0, 1'b1, 8'd3);
    rows[3] = make_row(16'd35, 32'd3, 32'd5, 32'h8000_0001, '1, 1'b0, 8'd3);
    rows[4] = make_row(16'd64, 32'hffff_fff1, 32'h0000_0100, 32'hf00f_0f00, '0, 1'b1, 8'd4);
    rows[5] = make_row(16'd0, 32'd9, 32'd9, '1, '1, 1'b0, 8'd0);   // Empty run
    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r], r);
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
